/* cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

	// Cause.ExcCode values
	typedef enum logic [4:0] {
		EXC_NONE = 5'd0,
		EXC_ADEL = 5'd4,
		EXC_ADES = 5'd5,
		EXC_SYS  = 5'd8,
		EXC_BP   = 5'd9,
		EXC_RI   = 5'd10,
		EXC_OV   = 5'd12
	} exc_code_e;

	typedef enum logic [1:0] {
		SIZE_BYTE = 2'd0,
		SIZE_HALF = 2'd1,
		SIZE_WORD = 2'd2
	} mem_size_e;

	localparam logic [31:0] EXC_VECTOR = 32'hbfc0_0380;

	// CP0 register numbers
	localparam logic [4:0] CP0_BADVADDR = 5'd8;
	localparam logic [4:0] CP0_STATUS   = 5'd12;
	localparam logic [4:0] CP0_CAUSE    = 5'd13;
	localparam logic [4:0] CP0_EPC      = 5'd14;

	localparam int STATUS_EXL_BIT = 1;

	// BEV and EXL set out of reset
	localparam logic [31:0] STATUS_RST = 32'h0040_0002;

	// Software writable fields of Status (IM, EXL, IE) and Cause (IP1..IP0)
	localparam logic [31:0] STATUS_WMASK = 32'h0000_ff03;
	localparam logic [31:0] CAUSE_WMASK  = 32'h0000_0300;

	localparam int DMEM_AW = 8;

endpackage

`default_nettype wire

/* data_addr_check.sv */
`timescale 1ns/1ps
`default_nettype none

module data_addr_check (
	input  logic               memreq,
	input  logic               wr,
	input  logic [31:0]        addr,
	input  cpu_pkg::mem_size_e size,
	input  logic               addr_err_if,
	input  logic [31:0]        badvaddr_if,
	output logic [31:0]        badvaddr,
	output logic [1:0]         addr_err,
	output logic               m_req
);
	import cpu_pkg::*;

	logic misaligned;

	always_comb begin
		case (size)
			SIZE_HALF: misaligned = addr[0];
			SIZE_WORD: misaligned = |addr[1:0];
			default:   misaligned = 1'b0;
		endcase
	end

	// Bit 1 flags a load, bit 0 a store
	assign addr_err[1] = memreq & misaligned & ~wr;
	assign addr_err[0] = memreq & misaligned & wr;

	// Fetch error also kills the data access
	assign m_req = memreq & ~misaligned & ~addr_err_if;

	assign badvaddr = addr_err_if ? badvaddr_if : addr;

	always_comb begin
		assert final (!(m_req && addr_err != 2'b00))
			else $error("data_addr_check: request issued with address error %b", addr_err);
	end

endmodule

`default_nettype wire

/* exc_handler.sv */
`timescale 1ns/1ps
`default_nettype none

module exc_handler (
	input  logic               is_instr,
	input  logic               status_exl,
	input  logic               in_delay_slot,
	input  logic [31:0]        pc,
	input  logic [31:0]        badvaddr,
	input  logic               addr_err_if,
	input  logic [1:0]         addr_err,
	input  logic               reserved_instr,
	input  logic               intovf,
	input  logic               mips_break,
	input  logic               syscall,
	input  logic               eret,
	output logic               exc_valid,
	output cpu_pkg::exc_code_e exc_code,
	output logic [31:0]        epc_wdata,
	output logic               bd_wdata,
	output logic               badvaddr_wen,
	output logic [31:0]        badvaddr_wdata,
	output logic               eret_commit
);
	import cpu_pkg::*;

	// Fixed priority with the fetch side first
	always_comb begin
		exc_code = EXC_NONE;
		if (is_instr) begin
			if (addr_err_if) begin
				exc_code = EXC_ADEL;
			end else if (reserved_instr) begin
				exc_code = EXC_RI;
			end else if (intovf) begin
				exc_code = EXC_OV;
			end else if (syscall) begin
				exc_code = EXC_SYS;
			end else if (mips_break) begin
				exc_code = EXC_BP;
			end else if (addr_err[1]) begin
				exc_code = EXC_ADEL;
			end else if (addr_err[0]) begin
				exc_code = EXC_ADES;
			end
		end
	end

	assign exc_valid = (exc_code != EXC_NONE);

	// Branch owns the delay slot
	assign epc_wdata = in_delay_slot ? pc - 32'd4 : pc;

	// BD stays frozen while EXL holds
	assign bd_wdata = in_delay_slot & ~status_exl;

	assign badvaddr_wen   = exc_valid & ((exc_code == EXC_ADEL) | (exc_code == EXC_ADES));
	assign badvaddr_wdata = badvaddr;

	assign eret_commit = is_instr & eret & ~exc_valid;

	always_comb begin
		assert final (!(exc_valid && eret_commit))
			else $error("exc_handler: exception and eret committed together");
	end

endmodule

`default_nettype wire

/* sram_wsig_adjust.sv */
`timescale 1ns/1ps
`default_nettype none

module sram_wsig_adjust (
	input  logic               req,
	input  logic               wr,
	input  logic [31:0]        in,
	input  cpu_pkg::mem_size_e size,
	input  logic [1:0]         memoffset,
	output logic [31:0]        out,
	output logic [3:0]         wen
);
	import cpu_pkg::*;

	logic [3:0] lane_sel;

	// Sub-word data is copied to every lane so the RAM picks it up by enables
	always_comb begin
		case (size)
			SIZE_BYTE: begin
				out      = {4{in[7:0]}};
				lane_sel = 4'b0001 << memoffset;
			end
			SIZE_HALF: begin
				out      = {2{in[15:0]}};
				lane_sel = memoffset[1] ? 4'b1100 : 4'b0011;
			end
			default: begin
				out      = in;
				lane_sel = 4'b1111;
			end
		endcase
	end

	assign wen = (req && wr) ? lane_sel : 4'b0000;

endmodule

`default_nettype wire

/* mem_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_stage (
	input  logic               is_instr,
	input  logic [31:0]        pc,
	input  logic [31:0]        ex_out,
	input  logic [31:0]        rtdata,
	input  logic               in_delay_slot,
	input  logic               intovf,
	input  logic               addr_err_if,
	input  logic               memreq,
	input  logic               memwr,
	input  cpu_pkg::mem_size_e mem_size,
	input  logic               reserved_instr,
	input  logic               mips_break,
	input  logic               syscall,
	input  logic               eret,
	input  logic               cp0_wen,
	input  logic [4:0]         cp0_waddr,
	input  logic [31:0]        cp0_epc,
	input  logic               cp0_status_exl,

	// SRAM-like interface
	output logic               m_data_req,
	output logic               m_data_wr,
	output logic [3:0]         m_data_wen,
	output logic [31:0]        m_data_addr,
	output logic [31:0]        m_data_wdata,

	// CP0 update
	output logic               exc_valid,
	output cpu_pkg::exc_code_e exc_code,
	output logic [31:0]        epc_wdata,
	output logic               bd_wdata,
	output logic               badvaddr_wen,
	output logic [31:0]        badvaddr_wdata,
	output logic               eret_commit,
	output logic               m_cp0_wen,
	output logic [4:0]         m_cp0_waddr,
	output logic [31:0]        m_cp0_wdata,

	output logic [31:0]        redirect_pc
);
	import cpu_pkg::*;

	logic [31:0] m_badvaddr;
	logic [1:0]  m_addr_err;
	logic        m_req;

	data_addr_check u_data_addr_check (
		.memreq      (memreq),
		.wr          (memwr),
		.addr        (ex_out),
		.size        (mem_size),
		.addr_err_if (addr_err_if),
		.badvaddr_if (pc),
		.badvaddr    (m_badvaddr),
		.addr_err    (m_addr_err),
		.m_req       (m_req)
	);

	exc_handler u_exc_handler (
		.is_instr       (is_instr),
		.status_exl     (cp0_status_exl),
		.in_delay_slot  (in_delay_slot),
		.pc             (pc),
		.badvaddr       (m_badvaddr),
		.addr_err_if    (addr_err_if),
		.addr_err       (m_addr_err),
		.reserved_instr (reserved_instr),
		.intovf         (intovf),
		.mips_break     (mips_break),
		.syscall        (syscall),
		.eret           (eret),
		.exc_valid      (exc_valid),
		.exc_code       (exc_code),
		.epc_wdata      (epc_wdata),
		.bd_wdata       (bd_wdata),
		.badvaddr_wen   (badvaddr_wen),
		.badvaddr_wdata (badvaddr_wdata),
		.eret_commit    (eret_commit)
	);

	sram_wsig_adjust u_sram_wsig_adjust (
		.req       (m_req),
		.wr        (memwr),
		.in        (rtdata),
		.size      (mem_size),
		.memoffset (ex_out[1:0]),
		.out       (m_data_wdata),
		.wen       (m_data_wen)
	);

	assign m_data_req  = m_req;
	assign m_data_wr   = memwr;
	assign m_data_addr = ex_out;

	// Bubbles never write CP0
	assign m_cp0_wen   = cp0_wen & is_instr;
	assign m_cp0_waddr = cp0_waddr;
	assign m_cp0_wdata = rtdata;

	assign redirect_pc = exc_valid ? EXC_VECTOR : (eret_commit ? cp0_epc : 32'h0);

endmodule

`default_nettype wire

/* cp0_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module cp0_regs (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               exc_valid,
	input  cpu_pkg::exc_code_e exc_code,
	input  logic [31:0]        epc_wdata,
	input  logic               bd_wdata,
	input  logic               badvaddr_wen,
	input  logic [31:0]        badvaddr_wdata,
	input  logic               eret_commit,
	input  logic               cp0_wen,
	input  logic [4:0]         cp0_waddr,
	input  logic [31:0]        cp0_wdata,
	output logic [31:0]        epc,
	output logic [31:0]        status,
	output logic [31:0]        cause,
	output logic [31:0]        badvaddr
);
	import cpu_pkg::*;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			epc      <= 32'h0;
			status   <= STATUS_RST;
			cause    <= 32'h0;
			badvaddr <= 32'h0;
		end else if (exc_valid) begin
			status[STATUS_EXL_BIT] <= 1'b1;
			cause[6:2]             <= exc_code;
			// Nested exception keeps the first return point
			if (!status[STATUS_EXL_BIT]) begin
				epc       <= epc_wdata;
				cause[31] <= bd_wdata;
			end
			if (badvaddr_wen) begin
				badvaddr <= badvaddr_wdata;
			end
		end else if (eret_commit) begin
			status[STATUS_EXL_BIT] <= 1'b0;
		end else if (cp0_wen) begin
			case (cp0_waddr)
				CP0_EPC:      epc      <= cp0_wdata;
				CP0_BADVADDR: badvaddr <= cp0_wdata;
				CP0_STATUS:   status   <= (status & ~STATUS_WMASK) | (cp0_wdata & STATUS_WMASK);
				CP0_CAUSE:    cause    <= (cause & ~CAUSE_WMASK) | (cp0_wdata & CAUSE_WMASK);
				default:      ;
			endcase
		end
	end

	exl_after_exc: assert property (
		@(posedge clk) disable iff (!rst_n)
		exc_valid |=> status[STATUS_EXL_BIT]
	) else $error("cp0_regs: EXL clear after exception");

endmodule

`default_nettype wire

/* data_sram.sv */
`timescale 1ns/1ps
`default_nettype none

module data_sram (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       req,
	input  logic                       wr,
	input  logic [3:0]                 wen,
	input  logic [cpu_pkg::DMEM_AW+1:0] addr,
	input  logic [31:0]                wdata,
	output logic [31:0]                rdata
);
	import cpu_pkg::*;

	logic [31:0]        mem [0:(1 << DMEM_AW) - 1];
	logic [DMEM_AW-1:0] word_addr;

	assign word_addr = addr[DMEM_AW+1:2];

	always_ff @(posedge clk) begin
		if (req && wr) begin
			for (int i = 0; i < 4; i++) begin
				if (wen[i]) begin
					mem[word_addr][8*i +: 8] <= wdata[8*i +: 8];
				end
			end
		end
	end

	// Read data holds until the next read
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rdata <= 32'h0;
		end else if (req && !wr) begin
			rdata <= mem[word_addr];
		end
	end

	wen_only_on_write: assert property (
		@(posedge clk) disable iff (!rst_n)
		(wen != 4'b0000) |-> (req && wr)
	) else $error("data_sram: byte enables %b without a write request", wen);

endmodule

`default_nettype wire

/* mem_top.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_top (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               is_instr,
	input  logic [31:0]        pc,
	input  logic [31:0]        ex_out,
	input  logic [31:0]        rtdata,
	input  logic               in_delay_slot,
	input  logic               intovf,
	input  logic               addr_err_if,
	input  logic               memreq,
	input  logic               memwr,
	input  cpu_pkg::mem_size_e mem_size,
	input  logic               reserved_instr,
	input  logic               mips_break,
	input  logic               syscall,
	input  logic               eret,
	input  logic               cp0_wen,
	input  logic [4:0]         cp0_waddr,
	output logic               exc_valid,
	output logic [31:0]        redirect_pc,
	output logic [31:0]        data_rdata,
	output logic [31:0]        cp0_epc,
	output logic [31:0]        cp0_status,
	output logic [31:0]        cp0_cause,
	output logic [31:0]        cp0_badvaddr
);
	import cpu_pkg::*;

	logic        m_data_req;
	logic        m_data_wr;
	logic [3:0]  m_data_wen;
	logic [31:0] m_data_addr;
	logic [31:0] m_data_wdata;
	exc_code_e   exc_code;
	logic [31:0] epc_wdata;
	logic        bd_wdata;
	logic        badvaddr_wen;
	logic [31:0] badvaddr_wdata;
	logic        eret_commit;
	logic        m_cp0_wen;
	logic [4:0]  m_cp0_waddr;
	logic [31:0] m_cp0_wdata;

	mem_stage u_mem_stage (
		.is_instr       (is_instr),
		.pc             (pc),
		.ex_out         (ex_out),
		.rtdata         (rtdata),
		.in_delay_slot  (in_delay_slot),
		.intovf         (intovf),
		.addr_err_if    (addr_err_if),
		.memreq         (memreq),
		.memwr          (memwr),
		.mem_size       (mem_size),
		.reserved_instr (reserved_instr),
		.mips_break     (mips_break),
		.syscall        (syscall),
		.eret           (eret),
		.cp0_wen        (cp0_wen),
		.cp0_waddr      (cp0_waddr),
		.cp0_epc        (cp0_epc),
		.cp0_status_exl (cp0_status[STATUS_EXL_BIT]),
		.m_data_req     (m_data_req),
		.m_data_wr      (m_data_wr),
		.m_data_wen     (m_data_wen),
		.m_data_addr    (m_data_addr),
		.m_data_wdata   (m_data_wdata),
		.exc_valid      (exc_valid),
		.exc_code       (exc_code),
		.epc_wdata      (epc_wdata),
		.bd_wdata       (bd_wdata),
		.badvaddr_wen   (badvaddr_wen),
		.badvaddr_wdata (badvaddr_wdata),
		.eret_commit    (eret_commit),
		.m_cp0_wen      (m_cp0_wen),
		.m_cp0_waddr    (m_cp0_waddr),
		.m_cp0_wdata    (m_cp0_wdata),
		.redirect_pc    (redirect_pc)
	);

	cp0_regs u_cp0_regs (
		.clk            (clk),
		.rst_n          (rst_n),
		.exc_valid      (exc_valid),
		.exc_code       (exc_code),
		.epc_wdata      (epc_wdata),
		.bd_wdata       (bd_wdata),
		.badvaddr_wen   (badvaddr_wen),
		.badvaddr_wdata (badvaddr_wdata),
		.eret_commit    (eret_commit),
		.cp0_wen        (m_cp0_wen),
		.cp0_waddr      (m_cp0_waddr),
		.cp0_wdata      (m_cp0_wdata),
		.epc            (cp0_epc),
		.status         (cp0_status),
		.cause          (cp0_cause),
		.badvaddr       (cp0_badvaddr)
	);

	// Only the low byte address bits reach the RAM
	data_sram u_data_sram (
		.clk   (clk),
		.rst_n (rst_n),
		.req   (m_data_req),
		.wr    (m_data_wr),
		.wen   (m_data_wen),
		.addr  (m_data_addr[DMEM_AW+1:0]),
		.wdata (m_data_wdata),
		.rdata (data_rdata)
	);

endmodule

`default_nettype wire

/* tb_mem_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_mem_top;
	import cpu_pkg::*;

	logic        clk;
	logic        rst_n;
	logic        is_instr;
	logic [31:0] pc;
	logic [31:0] ex_out;
	logic [31:0] rtdata;
	logic        in_delay_slot;
	logic        intovf;
	logic        addr_err_if;
	logic        memreq;
	logic        memwr;
	mem_size_e   mem_size;
	logic        reserved_instr;
	logic        mips_break;
	logic        syscall;
	logic        eret;
	logic        cp0_wen;
	logic [4:0]  cp0_waddr;
	logic        exc_valid;
	logic [31:0] redirect_pc;
	logic [31:0] data_rdata;
	logic [31:0] cp0_epc, cp0_status, cp0_cause, cp0_badvaddr;

	// Shadow RAM, shadow CP0 and expected combinational outputs
	logic [31:0] sh_mem [0:255];
	logic [31:0] sh_rdata, sh_epc, sh_status, sh_cause, sh_badvaddr;
	logic        misaligned;
	logic        data_req;
	logic        exp_exc;
	logic        exp_eret;
	logic [4:0]  exp_code;
	logic [31:0] exp_redirect;
	logic [31:0] next_pc;
	integer      seed;
	integer      error_count;

	mem_top dut (.*);

	always #10 clk = ~clk;

	function automatic logic [31:0] merge_store(input logic [31:0] old, input logic [31:0] data,
		input mem_size_e size, input logic [1:0] off);
		logic [31:0] word;
		word = old;
		case (size)
			SIZE_BYTE: word[8*off +: 8] = data[7:0];
			SIZE_HALF: word[16*off[1] +: 16] = data[15:0];
			default:   word = data;
		endcase
		return word;
	endfunction

	always_comb begin
		misaligned = memreq && ((mem_size == SIZE_HALF && ex_out[0]) ||
			(mem_size == SIZE_WORD && ex_out[1:0] != 2'b00));
		data_req = memreq && !misaligned && !addr_err_if;
		exp_code = !is_instr           ? EXC_NONE :
			addr_err_if          ? EXC_ADEL :
			reserved_instr       ? EXC_RI :
			intovf               ? EXC_OV :
			syscall              ? EXC_SYS :
			mips_break           ? EXC_BP :
			misaligned && !memwr ? EXC_ADEL :
			misaligned           ? EXC_ADES : EXC_NONE;
		exp_exc = (exp_code != 5'd0);
		exp_eret = is_instr && eret && !exp_exc;
		exp_redirect = exp_exc ? EXC_VECTOR : sh_epc;
	end

	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sh_rdata <= 32'h0;
			sh_epc <= 32'h0;
			sh_status <= 32'h0040_0002;
			sh_cause <= 32'h0;
			sh_badvaddr <= 32'h0;
		end else begin
			if (data_req && memwr)
				sh_mem[ex_out[9:2]] <= merge_store(sh_mem[ex_out[9:2]], rtdata,
					mem_size, ex_out[1:0]);
			else if (data_req)
				sh_rdata <= sh_mem[ex_out[9:2]];
			if (exp_exc) begin
				sh_status[1] <= 1'b1;
				sh_cause[6:2] <= exp_code;
				if (!sh_status[1]) begin
					sh_epc <= in_delay_slot ? pc - 32'd4 : pc;
					sh_cause[31] <= in_delay_slot;
				end
				if (exp_code == EXC_ADEL || exp_code == EXC_ADES)
					sh_badvaddr <= addr_err_if ? pc : ex_out;
			end else if (exp_eret) begin
				sh_status[1] <= 1'b0;
			end else if (is_instr && cp0_wen) begin
				// Status keeps IM, EXL and IE writable and Cause only IP1..IP0
				case (cp0_waddr)
					CP0_EPC:      sh_epc <= rtdata;
					CP0_BADVADDR: sh_badvaddr <= rtdata;
					CP0_STATUS:   sh_status <= (sh_status & ~32'h0000_ff03) |
						(rtdata & 32'h0000_ff03);
					CP0_CAUSE:    sh_cause <= (sh_cause & ~32'h0000_0300) |
						(rtdata & 32'h0000_0300);
					default:      ;
				endcase
			end
		end
	end

	task automatic abort_run();
		$display("Done: errors found");
		$fatal(1, "simulation stopped");
	endtask

	task automatic report_mismatch(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		error_count++;
		$display("MISMATCH time=%0t signal=%s got=%h expected=%h", $time, name, got, exp);
		abort_run();
	endtask

	check_exc_valid: assert property (@(posedge clk) disable iff (!rst_n) exc_valid == exp_exc)
		else report_mismatch("exc_valid", 32'($sampled(exc_valid)), 32'($sampled(exp_exc)));

	check_redirect: assert property (@(posedge clk) disable iff (!rst_n)
		(exp_exc || exp_eret) |-> redirect_pc == exp_redirect)
		else report_mismatch("redirect_pc", $sampled(redirect_pc), $sampled(exp_redirect));

	check_rdata: assert property (@(posedge clk) disable iff (!rst_n) data_rdata === sh_rdata)
		else report_mismatch("data_rdata", $sampled(data_rdata), $sampled(sh_rdata));

	check_epc: assert property (@(posedge clk) disable iff (!rst_n) cp0_epc == sh_epc)
		else report_mismatch("cp0_epc", $sampled(cp0_epc), $sampled(sh_epc));

	check_status: assert property (@(posedge clk) disable iff (!rst_n) cp0_status == sh_status)
		else report_mismatch("cp0_status", $sampled(cp0_status), $sampled(sh_status));

	check_cause: assert property (@(posedge clk) disable iff (!rst_n) cp0_cause == sh_cause)
		else report_mismatch("cp0_cause", $sampled(cp0_cause), $sampled(sh_cause));

	check_badvaddr: assert property (@(posedge clk) disable iff (!rst_n)
		cp0_badvaddr == sh_badvaddr)
		else report_mismatch("cp0_badvaddr", $sampled(cp0_badvaddr), $sampled(sh_badvaddr));

	task automatic set_bubble();
		is_instr = 1'b0;
		pc = 32'h0;
		ex_out = 32'h0;
		rtdata = 32'h0;
		in_delay_slot = 1'b0;
		intovf = 1'b0;
		addr_err_if = 1'b0;
		memreq = 1'b0;
		memwr = 1'b0;
		mem_size = SIZE_BYTE;
		reserved_instr = 1'b0;
		mips_break = 1'b0;
		syscall = 1'b0;
		eret = 1'b0;
		cp0_wen = 1'b0;
		cp0_waddr = 5'd0;
	endtask

	// Inputs change 2 ns after the edge that consumes them
	task automatic step();
		@(posedge clk);
		#2;
		set_bubble();
	endtask

	task automatic begin_instr();
		is_instr = 1'b1;
		pc = next_pc;
		next_pc = next_pc + 32'd4;
	endtask

	task automatic mem_op(input logic wr, input mem_size_e size, input logic [31:0] addr,
		input logic [31:0] data);
		begin_instr();
		memreq = 1'b1;
		memwr = wr;
		mem_size = size;
		ex_out = addr;
		rtdata = data;
		step();
	endtask

	task automatic raise_flags(input logic [3:0] flags, input logic ds);
		begin_instr();
		{reserved_instr, intovf, syscall, mips_break} = flags;
		in_delay_slot = ds;
		step();
	endtask

	task automatic mtc0(input logic [4:0] regnum, input logic [31:0] value);
		begin_instr();
		cp0_wen = 1'b1;
		cp0_waddr = regnum;
		rtdata = value;
		step();
	endtask

	task automatic wait_exl(input logic value);
		int n;
		n = 0;
		while (cp0_status[STATUS_EXL_BIT] !== value) begin
			if (n == 8) begin
				$display("Timeout: Status.EXL did not become %0b", value);
				abort_run();
			end
			@(posedge clk);
			#2;
			n++;
		end
	endtask

	task automatic exc_return();
		begin_instr();
		eret = 1'b1;
		step();
		wait_exl(1'b0);
	endtask

	initial begin
		logic [31:0] addr;
		logic [1:0]  size;
		logic [1:0]  off;
		seed = 77;
		error_count = 0;
		next_pc = 32'h8000_1000;
		clk = 1'b0;
		rst_n = 1'b0;
		set_bubble();
		repeat (5) @(posedge clk);
		#2;
		rst_n = 1'b1;
		exc_return();

		// Full word first, then a sized store into it, then read back
		repeat (16) begin
			addr = $random(seed) & 32'h0000_03fc;
			mem_op(1'b1, SIZE_WORD, addr, $random(seed));
			size = 2'($unsigned($random(seed)) % 3);
			off = 2'($random(seed));
			if (size == 2'd1)
				off[0] = 1'b0;
			else if (size == 2'd2)
				off = 2'b00;
			mem_op(1'b1, mem_size_e'(size), addr | {30'h0, off}, $random(seed));
			mem_op(1'b0, SIZE_WORD, addr, 32'h0);
		end

		// Misaligned accesses must not touch the RAM
		addr = 32'h0000_0100;
		mem_op(1'b1, SIZE_WORD, addr, 32'h1234_5678);
		mem_op(1'b0, SIZE_WORD, addr | 32'd2, 32'h0);
		exc_return();
		mem_op(1'b1, SIZE_HALF, addr | 32'd1, 32'hdead_beef);
		exc_return();
		mem_op(1'b0, SIZE_WORD, addr, 32'h0);
		begin_instr();
		addr_err_if = 1'b1;
		step();
		exc_return();

		// Priority sweep where later ones nest under EXL
		for (int f = 15; f > 0; f--)
			raise_flags(4'(f), 1'b0);
		begin_instr();
		intovf = 1'b1;
		memreq = 1'b1;
		mem_size = SIZE_WORD;
		ex_out = 32'h0000_0003;
		step();
		begin_instr();
		addr_err_if = 1'b1;
		reserved_instr = 1'b1;
		step();
		exc_return();

		// Delay slot exception and then a nested one that keeps EPC and BD
		raise_flags(4'b0010, 1'b1);
		raise_flags(4'b0001, 1'b0);
		exc_return();

		mtc0(CP0_EPC, $random(seed));
		mtc0(CP0_STATUS, 32'hffff_ffff);
		mtc0(CP0_CAUSE, $random(seed));
		mtc0(CP0_BADVADDR, $random(seed));
		mtc0(CP0_STATUS, 32'h0000_0000);
		exc_return();
		// Exception wins over MTC0 in the same cycle
		begin_instr();
		cp0_wen = 1'b1;
		cp0_waddr = CP0_EPC;
		rtdata = 32'h1111_2222;
		syscall = 1'b1;
		step();
		exc_return();
		repeat (3) begin
			begin_instr();
			step();
		end
		repeat (2) step();

		if (error_count == 0) begin
			$display("Done: no errors");
			$finish;
		end else begin
			abort_run();
		end
	end

endmodule

`default_nettype wire

/* flist.f */
cpu_pkg.sv
data_addr_check.sv
exc_handler.sv
sram_wsig_adjust.sv
mem_stage.sv
cp0_regs.sv
data_sram.sv
mem_top.sv
tb_mem_top.sv

/* Bender.yml */
package:
  name: mips_mem_stage

sources:
  - cpu_pkg.sv
  - data_addr_check.sv
  - exc_handler.sv
  - sram_wsig_adjust.sv
  - mem_stage.sv
  - cp0_regs.sv
  - data_sram.sv
  - mem_top.sv
  - target: test
    files:
      - tb_mem_top.sv
